/* rtl/md_params.svh */
// RV32M multiply/divide unit
// shared widths and iteration counts for the multiplier and divider datapaths

`ifndef MD_PARAMS_SVH
`define MD_PARAMS_SVH

`default_nettype none

// operand and result width
`define MD_WORD_W 32
// slice width fed to the 17x17 MAC core
`define MD_HALF_W 16
// accumulator and intermediate register width
`define MD_ACC_W 34
// one restoring step per quotient bit
`define MD_DIV_STEPS 32
// wide enough to count down from MD_DIV_STEPS-1
`define MD_CNT_W 5

`default_nettype wire

`endif

/* rtl/md_op_pkg.sv */
// RV32M multiply/divide unit
// instruction side types: operator class and operand sign mode

`default_nettype none

package md_op_pkg;

  // operator class, the sign mode refines it into the eight RV32M ops
  // MULL    -> MUL
  // MULH    -> MULH / MULHSU / MULHU
  // DIV     -> DIV / DIVU
  // REM     -> REM / REMU
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // bit 0 set: operand a is signed
  // bit 1 set: operand b is signed
  typedef logic [1:0] sign_mode_t;

  // bit positions inside sign_mode_t
  localparam int unsigned SIGN_A_BIT = 0;
  localparam int unsigned SIGN_B_BIT = 1;

endpackage

`default_nettype wire

/* rtl/md_arith_pkg.sv */
// RV32M multiply/divide unit
// datapath types shared by both engines and the top level

`include "md_params.svh"

`default_nettype none

package md_arith_pkg;

  // full operand / result word
  typedef logic [`MD_WORD_W-1:0] md_word_t;

  // half word, one MAC operand slice
  typedef logic [`MD_HALF_W-1:0] md_half_t;

  // accumulator, two bits wider than a word
  // top bits carry sign and carry of the partial sums
  // the divider keeps its shifted remainder in the same width
  typedef logic [`MD_ACC_W-1:0] md_acc_t;

endpackage

`default_nettype wire

/* rtl/md_mult_fast.sv */
// RV32M multiplier
// one signed 17x17 MAC core stepped over four 16x16 partial products
// MUL finishes in its 3rd state, MULH/MULHSU/MULHU in the 4th

`timescale 1ns/100ps

`include "md_params.svh"

`default_nettype none

module md_mult_fast
  import md_op_pkg::*, md_arith_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  md_op_e     op_i,
  input  sign_mode_t sign_mode_i,
  input  md_word_t   op_a_i,
  input  md_word_t   op_b_i,
  output logic       done_o,
  output md_word_t   result_o
);

  typedef enum logic [2:0] {
    MULT_IDLE,
    MULT_ALBL,
    MULT_ALBH,
    MULT_AHBL,
    MULT_AHBH
  } mult_fsm_e;

  mult_fsm_e mult_state_q, mult_state_d;

  // operand slices
  md_half_t  a_lo, a_hi, b_lo, b_hi;
  // MAC core inputs
  md_half_t  mult_op_a, mult_op_b;
  logic      sign_a, sign_b;
  md_acc_t   accum;
  // MAC output and the value written back to the accumulator
  md_acc_t   mac_res, mac_res_d;
  md_acc_t   accum_q;
  logic      signed_mult;

  assign a_lo = op_a_i[`MD_HALF_W-1:0];
  assign a_hi = op_a_i[`MD_WORD_W-1:`MD_HALF_W];
  assign b_lo = op_b_i[`MD_HALF_W-1:0];
  assign b_hi = op_b_i[`MD_WORD_W-1:`MD_HALF_W];

  // any signed operand makes the partial sums signed
  assign signed_mult = (sign_mode_i != 2'b00);

  // 34-bit result is enough, the two top bits of the exact sum always agree
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) +
                   $signed(accum);

  always_comb begin
    mult_op_a    = a_lo;
    mult_op_b    = b_lo;
    sign_a       = 1'b0;
    sign_b       = 1'b0;
    accum        = accum_q;
    mac_res_d    = mac_res;
    mult_state_d = mult_state_q;
    done_o       = 1'b0;

    unique case (mult_state_q)
      MULT_IDLE: begin
        if (start_i) begin
          mult_state_d = MULT_ALBL;
        end
      end

      MULT_ALBL: begin
        // al*bl, always unsigned, nothing to add yet
        accum        = '0;
        mult_state_d = MULT_ALBH;
      end

      MULT_ALBH: begin
        // al*bh << 16, add the upper half of al*bl
        mult_op_b = b_hi;
        sign_b    = sign_mode_i[SIGN_B_BIT] & op_b_i[`MD_WORD_W-1];
        accum     = {{(`MD_ACC_W-`MD_HALF_W){1'b0}}, accum_q[`MD_WORD_W-1:`MD_HALF_W]};
        if (op_i == MD_OP_MULL) begin
          // keep only the low word, bits 15:0 are final already
          mac_res_d = {{(`MD_ACC_W-`MD_WORD_W){1'b0}}, mac_res[`MD_HALF_W-1:0],
                       accum_q[`MD_HALF_W-1:0]};
        end
        mult_state_d = MULT_AHBL;
      end

      MULT_AHBL: begin
        // ah*bl << 16
        mult_op_a = a_hi;
        sign_a    = sign_mode_i[SIGN_A_BIT] & op_a_i[`MD_WORD_W-1];
        if (op_i == MD_OP_MULL) begin
          // low word complete here
          accum     = {{(`MD_ACC_W-`MD_HALF_W){1'b0}}, accum_q[`MD_WORD_W-1:`MD_HALF_W]};
          mac_res_d = {{(`MD_ACC_W-`MD_WORD_W){1'b0}}, mac_res[`MD_HALF_W-1:0],
                       accum_q[`MD_HALF_W-1:0]};
          done_o       = 1'b1;
          mult_state_d = MULT_IDLE;
        end else begin
          mult_state_d = MULT_AHBH;
        end
      end

      MULT_AHBH: begin
        // ah*bh << 32 plus the middle sum shifted down a half word
        mult_op_a = a_hi;
        mult_op_b = b_hi;
        sign_a    = sign_mode_i[SIGN_A_BIT] & op_a_i[`MD_WORD_W-1];
        sign_b    = sign_mode_i[SIGN_B_BIT] & op_b_i[`MD_WORD_W-1];
        // middle sum is unsigned only for MULHU
        accum     = {{`MD_HALF_W{signed_mult & accum_q[`MD_ACC_W-1]}},
                     accum_q[`MD_ACC_W-1:`MD_HALF_W]};
        done_o       = 1'b1;
        mult_state_d = MULT_IDLE;
      end

      default: begin
        mult_state_d = MULT_IDLE;
      end
    endcase
  end

  // upper word for MULH, low word for MUL
  assign result_o = mac_res_d[`MD_WORD_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_state_q <= MULT_IDLE;
    end else begin
      mult_state_q <= mult_state_d;
    end
  end

  // intermediate partial sum, written on every active step
  always_ff @(posedge clk_i) begin
    if (mult_state_q != MULT_IDLE) begin
      accum_q <= mac_res_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/md_div_long.sv */
// RV32M divider
// restoring long division on absolute values with a final sign fix
// a local 33-bit adder does every negation and trial subtraction

`timescale 1ns/100ps

`include "md_params.svh"

`default_nettype none

module md_div_long
  import md_op_pkg::*, md_arith_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  md_op_e     op_i,
  input  sign_mode_t sign_mode_i,
  input  md_word_t   op_a_i,
  input  md_word_t   op_b_i,
  output logic       done_o,
  output md_word_t   result_o
);

  typedef enum logic [2:0] {
    MD_IDLE,
    MD_ABS_A,
    MD_ABS_B,
    MD_COMP,
    MD_LAST,
    MD_CHANGE_SIGN,
    MD_FINISH
  } md_fsm_e;

  md_fsm_e md_state_q, md_state_d;

  logic [`MD_CNT_W-1:0] cnt_q, cnt_d;
  md_word_t num_q, num_d;
  md_word_t den_q, den_d;
  md_word_t quot_q, quot_d;
  // shifted remainder, reused for the final result
  md_acc_t  rem_q, rem_d;

  // adder computes add_a + add_b, bit 0 of both is the carry in
  logic [`MD_WORD_W:0] add_a, add_b, adder_ext;
  md_word_t adder_res;

  logic     sign_a, sign_b, b_zero;
  logic     is_ge;
  logic     div_change_sign, rem_change_sign;
  md_word_t one_shift, next_rem, next_quot;

  assign adder_ext = add_a + add_b;
  assign adder_res = adder_ext[`MD_WORD_W:1];

  assign sign_a = op_a_i[`MD_WORD_W-1] & sign_mode_i[SIGN_A_BIT];
  assign sign_b = op_b_i[`MD_WORD_W-1] & sign_mode_i[SIGN_B_BIT];
  assign b_zero = (op_b_i == '0);

  // quotient sign flips only on a real division with mixed signs
  assign div_change_sign = (sign_a ^ sign_b) & ~b_zero;
  // remainder follows the dividend
  assign rem_change_sign = sign_a;

  // remainder >= denominator, compared as unsigned
  // the denominator may be 2^31 after taking |most negative|
  assign is_ge = (rem_q[`MD_WORD_W-1] == den_q[`MD_WORD_W-1]) ?
                 ~adder_res[`MD_WORD_W-1] : rem_q[`MD_WORD_W-1];

  assign one_shift = md_word_t'(1) << cnt_q;
  assign next_rem  = is_ge ? adder_res : rem_q[`MD_WORD_W-1:0];
  assign next_quot = is_ge ? (quot_q | one_shift) : quot_q;

  always_comb begin
    md_state_d = md_state_q;
    cnt_d      = cnt_q - 1'b1;
    num_d      = num_q;
    den_d      = den_q;
    quot_d     = quot_q;
    rem_d      = rem_q;
    // default is 0 - b
    add_a      = {{`MD_WORD_W{1'b0}}, 1'b1};
    add_b      = {~op_b_i, 1'b1};

    unique case (md_state_q)
      MD_IDLE: begin
        cnt_d = cnt_q;
        if (start_i) begin
          // preload the zero divisor answer, kept only if we skip to FINISH
          if (op_i == MD_OP_DIV) begin
            rem_d = '1;
          end else begin
            rem_d = {{(`MD_ACC_W-`MD_WORD_W){1'b0}}, op_a_i};
          end
          md_state_d = b_zero ? MD_FINISH : MD_ABS_A;
          cnt_d      = `MD_CNT_W'(`MD_DIV_STEPS - 1);
        end
      end

      MD_ABS_A: begin
        // |a| = 0 - a when a is negative
        add_b      = {~op_a_i, 1'b1};
        num_d      = sign_a ? adder_res : op_a_i;
        quot_d     = '0;
        cnt_d      = `MD_CNT_W'(`MD_DIV_STEPS - 1);
        md_state_d = MD_ABS_B;
      end

      MD_ABS_B: begin
        // |b| = 0 - b, first numerator bit enters the remainder
        den_d      = sign_b ? adder_res : op_b_i;
        rem_d      = {{(`MD_ACC_W-1){1'b0}}, num_q[`MD_WORD_W-1]};
        cnt_d      = `MD_CNT_W'(`MD_DIV_STEPS - 1);
        md_state_d = MD_COMP;
      end

      MD_COMP: begin
        // trial subtract remainder - denominator
        add_a      = {rem_q[`MD_WORD_W-1:0], 1'b1};
        add_b      = {~den_q, 1'b1};
        rem_d      = {1'b0, next_rem, num_q[cnt_d]};
        quot_d     = next_quot;
        md_state_d = (cnt_q == `MD_CNT_W'(1)) ? MD_LAST : MD_COMP;
      end

      MD_LAST: begin
        // bit 0 step, only the wanted result is kept
        add_a = {rem_q[`MD_WORD_W-1:0], 1'b1};
        add_b = {~den_q, 1'b1};
        if (op_i == MD_OP_DIV) begin
          rem_d = {{(`MD_ACC_W-`MD_WORD_W){1'b0}}, next_quot};
        end else begin
          rem_d = {{(`MD_ACC_W-`MD_WORD_W){1'b0}}, next_rem};
        end
        md_state_d = MD_CHANGE_SIGN;
      end

      MD_CHANGE_SIGN: begin
        // 0 - result where the sign has to flip
        add_b = {~rem_q[`MD_WORD_W-1:0], 1'b1};
        if ((op_i == MD_OP_DIV) ? div_change_sign : rem_change_sign) begin
          rem_d = {{(`MD_ACC_W-`MD_WORD_W){1'b0}}, adder_res};
        end
        md_state_d = MD_FINISH;
      end

      MD_FINISH: begin
        md_state_d = MD_IDLE;
      end

      default: begin
        md_state_d = MD_IDLE;
      end
    endcase
  end

  assign done_o   = (md_state_q == MD_FINISH);
  assign result_o = rem_q[`MD_WORD_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      md_state_q <= MD_IDLE;
      cnt_q      <= '0;
    end else begin
      md_state_q <= md_state_d;
      cnt_q      <= cnt_d;
    end
  end

  // datapath registers
  always_ff @(posedge clk_i) begin
    num_q  <= num_d;
    den_q  <= den_d;
    quot_q <= quot_d;
    rem_q  <= rem_d;
  end

endmodule

`default_nettype wire

/* rtl/md_unit.sv */
// RV32M multiply/divide unit, top level
// captures a request, starts the multiplier or divider and holds the
// result until the consumer takes it

`timescale 1ns/100ps

`default_nettype none

module md_unit
  import md_op_pkg::*, md_arith_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  md_op_e     op_i,
  input  sign_mode_t sign_mode_i,
  input  md_word_t   op_a_i,
  input  md_word_t   op_b_i,
  input  logic       ready_i,
  output logic       busy_o,
  output logic       valid_o,
  output md_word_t   result_o
);

  logic       accept, is_div;
  logic       busy_q, valid_q;
  logic       mult_start_q, div_start_q;
  logic       mult_done, div_done;
  md_op_e     op_q;
  sign_mode_t sign_mode_q;
  md_word_t   op_a_q, op_b_q;
  md_word_t   mult_result, div_result, result_q;

  // a start while busy is dropped
  assign accept = start_i & ~busy_q;
  assign is_div = (op_i == MD_OP_DIV) || (op_i == MD_OP_REM);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      valid_q      <= 1'b0;
      mult_start_q <= 1'b0;
      div_start_q  <= 1'b0;
    end else begin
      // engines see the strobe one cycle after capture
      mult_start_q <= accept & ~is_div;
      div_start_q  <= accept & is_div;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (valid_q && ready_i) begin
        busy_q <= 1'b0;
      end
      if (mult_done || div_done) begin
        valid_q <= 1'b1;
      end else if (valid_q && ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // request capture and result hold
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q        <= op_i;
      sign_mode_q <= sign_mode_i;
      op_a_q      <= op_a_i;
      op_b_q      <= op_b_i;
    end
    if (mult_done) begin
      result_q <= mult_result;
    end else if (div_done) begin
      result_q <= div_result;
    end
  end

  md_mult_fast u_mult (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (mult_start_q),
    .op_i        (op_q),
    .sign_mode_i (sign_mode_q),
    .op_a_i      (op_a_q),
    .op_b_i      (op_b_q),
    .done_o      (mult_done),
    .result_o    (mult_result)
  );

  md_div_long u_div (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (div_start_q),
    .op_i        (op_q),
    .sign_mode_i (sign_mode_q),
    .op_a_i      (op_a_q),
    .op_b_i      (op_b_q),
    .done_o      (div_done),
    .result_o    (div_result)
  );

  assign busy_o   = busy_q;
  assign valid_o  = valid_q;
  assign result_o = result_q;

endmodule

`default_nettype wire

/* bench/md_clk_gen.sv */
// testbench clock and reset source
// 4 ns clock, active low reset held for the first 16 cycles

`timescale 1ns/100ps

`default_nettype none

module md_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // release on a rising edge, same as any other driven input
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* bench/md_unit_properties.sv */
// handshake properties of the multiply/divide unit top level
// bound into every md_unit instance

`timescale 1ns/100ps

`default_nettype none

module md_unit_properties
  import md_arith_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     ready_i,
  input logic     busy_i,
  input logic     valid_i,
  input md_word_t result_i
);

  // a pending result always belongs to a busy unit
  valid_implies_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> busy_i
  ) else $error("valid_o high while busy_o is low");

  // back-pressure keeps the result and its valid in place
  result_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !ready_i) |=> (valid_i && $stable(result_i))
  ) else $error("result_o changed or valid_o fell while ready_i was low");

  // nothing pending while reset is held
  idle_in_reset: assert property (
    @(posedge clk_i)
    !rst_ni |-> (!busy_i && !valid_i)
  ) else $error("busy_o or valid_o high during reset");

endmodule

bind md_unit md_unit_properties u_props (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .ready_i  (ready_i),
  .busy_i   (busy_o),
  .valid_i  (valid_o),
  .result_i (result_o)
);

`default_nettype wire

/* bench/md_unit_tb.sv */
// testbench for the RV32M multiply/divide unit
// table-driven and random requests checked against an RV32M model
// every request also sees back-pressure and a dropped second start

`timescale 1ns/100ps

`include "md_params.svh"

`default_nettype none

module md_unit_tb
  import md_op_pkg::*, md_arith_pkg::*;
();

  localparam int TIMEOUT       = 100;
  localparam int RESET_TIMEOUT = 64;

  // one request with operator, sign mode, operands and cycles of ready low
  typedef struct packed {
    md_op_e     op;
    sign_mode_t mode;
    md_word_t   a;
    md_word_t   b;
    logic [3:0] delay;
  } vec_t;

  logic       clk, rst_n;
  logic       start, ready;
  md_op_e     op;
  sign_mode_t sign_mode;
  md_word_t   op_a, op_b;
  logic       busy, valid;
  md_word_t   result;

  vec_t        vec_q[$];
  logic [31:0] lcg_state;
  int          err_cnt, pass_cnt, fail_cnt;
  logic        timed_out;

  md_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  md_unit u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .start_i     (start),
    .op_i        (op),
    .sign_mode_i (sign_mode),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .ready_i     (ready),
    .busy_o      (busy),
    .valid_o     (valid),
    .result_o    (result)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // RV32M reference model
  // sign mode bit 0 marks a as signed and bit 1 marks b as signed
  function automatic md_word_t expected_result(input vec_t v);
    logic [2*`MD_WORD_W-1:0] ext_a, ext_b, prod;
    logic                    neg_a, neg_b;
    md_word_t                mag_a, mag_b, quot, rem;
    neg_a = v.mode[SIGN_A_BIT] & v.a[`MD_WORD_W-1];
    neg_b = v.mode[SIGN_B_BIT] & v.b[`MD_WORD_W-1];
    ext_a = {{`MD_WORD_W{neg_a}}, v.a};
    ext_b = {{`MD_WORD_W{neg_b}}, v.b};
    // low 64 bits of the extended product are exact
    prod  = ext_a * ext_b;
    if (v.op == MD_OP_MULL) begin
      return prod[`MD_WORD_W-1:0];
    end
    if (v.op == MD_OP_MULH) begin
      return prod[2*`MD_WORD_W-1:`MD_WORD_W];
    end
    // divide by zero gives all ones or the dividend
    if (v.b == '0) begin
      return (v.op == MD_OP_DIV) ? '1 : v.a;
    end
    mag_a = neg_a ? -v.a : v.a;
    mag_b = neg_b ? -v.b : v.b;
    quot  = mag_a / mag_b;
    rem   = mag_a % mag_b;
    // most negative / -1 wraps back to most negative here
    if (neg_a ^ neg_b) begin
      quot = -quot;
    end
    if (neg_a) begin
      rem = -rem;
    end
    return (v.op == MD_OP_DIV) ? quot : rem;
  endfunction

  function automatic string op_name(input vec_t v);
    case (v.op)
      MD_OP_MULL: return "MUL";
      MD_OP_MULH: return (v.mode == 2'b11) ? "MULH" : (v.mode == 2'b01) ? "MULHSU" : "MULHU";
      MD_OP_DIV:  return (v.mode == 2'b11) ? "DIV" : "DIVU";
      default:    return (v.mode == 2'b11) ? "REM" : "REMU";
    endcase
  endfunction

  task automatic check_result(input md_word_t got, input md_word_t exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic add_vec(input md_op_e op_v, input sign_mode_t mode_v, input md_word_t a_v,
                         input md_word_t b_v, input int delay_v);
    vec_t v;
    v.op    = op_v;
    v.mode  = mode_v;
    v.a     = a_v;
    v.b     = b_v;
    v.delay = 4'(delay_v);
    vec_q.push_back(v);
  endtask

  task automatic add_random(input int count);
    logic [31:0] r, a, b;
    md_op_e      op_v;
    sign_mode_t  mode_v;
    for (int i = 0; i < count; i++) begin
      r    = lcg_next();
      a    = lcg_next();
      b    = lcg_next();
      op_v = md_op_e'(r[1:0]);
      // only the eight RV32M encodings
      if (op_v == MD_OP_MULH && r[3]) begin
        mode_v = 2'b01;
      end else begin
        mode_v = r[2] ? 2'b11 : 2'b00;
      end
      // small divisors now and then including zero
      if (r[5:4] == 2'b00) begin
        b = b >> 24;
      end
      add_vec(op_v, mode_v, a, b, int'(r[9:8]));
    end
  endtask

  // corner operands, sign combinations, overflow and zero divisor
  task automatic build_table();
    add_vec(MD_OP_MULL, 2'b11, 32'h0000_0000, 32'h0000_0000, 0);
    add_vec(MD_OP_MULL, 2'b11, 32'h0000_0001, 32'hffff_ffff, 1);
    add_vec(MD_OP_MULL, 2'b11, 32'hffff_ffff, 32'hffff_ffff, 3);
    add_vec(MD_OP_MULL, 2'b11, 32'h8000_0000, 32'h7fff_ffff, 0);
    add_vec(MD_OP_MULL, 2'b00, 32'h7fff_ffff, 32'h7fff_ffff, 2);
    add_vec(MD_OP_MULH, 2'b11, 32'hffff_ffff, 32'hffff_ffff, 0);
    add_vec(MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000, 5);
    add_vec(MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h7fff_ffff, 1);
    add_vec(MD_OP_MULH, 2'b11, 32'h0000_0001, 32'hffff_ffff, 0);
    add_vec(MD_OP_MULH, 2'b01, 32'hffff_ffff, 32'hffff_ffff, 2);
    add_vec(MD_OP_MULH, 2'b01, 32'h8000_0000, 32'hffff_ffff, 0);
    add_vec(MD_OP_MULH, 2'b01, 32'h7fff_ffff, 32'h8000_0000, 4);
    add_vec(MD_OP_MULH, 2'b00, 32'hffff_ffff, 32'hffff_ffff, 0);
    add_vec(MD_OP_MULH, 2'b00, 32'h8000_0000, 32'h8000_0000, 1);
    add_vec(MD_OP_MULH, 2'b00, 32'h0000_0001, 32'hffff_ffff, 0);
    add_vec(MD_OP_DIV,  2'b11, 32'h8000_0000, 32'hffff_ffff, 2);
    add_vec(MD_OP_DIV,  2'b11, 32'hffff_fff9, 32'h0000_0002, 0);
    add_vec(MD_OP_DIV,  2'b11, 32'h0000_0007, 32'hffff_fffe, 1);
    add_vec(MD_OP_DIV,  2'b00, 32'hffff_ffff, 32'h0000_0002, 0);
    add_vec(MD_OP_REM,  2'b11, 32'h8000_0000, 32'hffff_ffff, 3);
    add_vec(MD_OP_REM,  2'b11, 32'hffff_fff9, 32'h0000_0002, 0);
    add_vec(MD_OP_REM,  2'b11, 32'h0000_0007, 32'hffff_fffe, 0);
    add_vec(MD_OP_REM,  2'b00, 32'hffff_ffff, 32'h0000_0010, 2);
    add_vec(MD_OP_DIV,  2'b11, 32'h0000_1234, 32'h0000_0000, 0);
    add_vec(MD_OP_DIV,  2'b00, 32'hffff_ffff, 32'h0000_0000, 1);
    add_vec(MD_OP_REM,  2'b11, 32'hffff_fffb, 32'h0000_0000, 0);
    add_vec(MD_OP_REM,  2'b00, 32'h0000_abcd, 32'h0000_0000, 6);
  endtask

  // one request with a dropped second start and a delayed transfer
  task automatic run_test(input int idx, input vec_t v, output logic ok);
    md_word_t exp_val;
    int       cnt, errs_before;
    ok          = 1'b1;
    exp_val     = expected_result(v);
    errs_before = err_cnt;
    cnt = 0;
    while (busy && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (busy) begin
      $display("test %0d failed: the unit stayed busy and never took a request", idx);
      fail_cnt++;
      ok = 1'b0;
      return;
    end
    @(posedge clk);
    start     <= 1'b1;
    op        <= v.op;
    sign_mode <= v.mode;
    op_a      <= v.a;
    op_b      <= v.b;
    // start stays high with other operands and lands while busy
    @(posedge clk);
    sign_mode <= ~v.mode;
    op_a      <= ~v.a;
    op_b      <= v.b + 32'd3;
    @(negedge clk);
    check_flag(busy, 1'b1, "busy after accepted start");
    @(posedge clk);
    start <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!valid && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!valid) begin
      $display("test %0d failed: no valid result within %0d cycles", idx, TIMEOUT);
      fail_cnt++;
      ok = 1'b0;
      return;
    end
    check_result(result, exp_val, {op_name(v), " result"});
    // result has to wait while ready is low
    for (int i = 0; i < int'(v.delay); i++) begin
      @(negedge clk);
      check_flag(valid, 1'b1, "valid while ready low");
      check_result(result, exp_val, "result while ready low");
    end
    @(posedge clk);
    ready <= 1'b1;
    @(posedge clk);
    ready <= 1'b0;
    @(negedge clk);
    check_flag(valid, 1'b0, "valid after transfer");
    check_flag(busy, 1'b0, "busy after transfer");
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %0d %s a=%08h b=%08h result=%08h ok", idx, op_name(v), v.a, v.b,
               exp_val);
    end else begin
      fail_cnt++;
      $display("test %0d %s a=%08h b=%08h failed", idx, op_name(v), v.a, v.b);
    end
  endtask

  initial begin
    logic run_ok;
    int   cnt;
    start     = 1'b0;
    ready     = 1'b0;
    op        = MD_OP_MULL;
    sign_mode = '0;
    op_a      = '0;
    op_b      = '0;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    timed_out = 1'b0;
    lcg_state = 32'h8895_5414;
    build_table();
    add_random(40);
    cnt = 0;
    while (rst_n !== 1'b1 && cnt < RESET_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      timed_out = 1'b1;
    end else begin
      // idle before the first request
      check_flag(busy, 1'b0, "busy after reset");
      check_flag(valid, 1'b0, "valid after reset");
      for (int i = 0; i < vec_q.size(); i++) begin
        run_test(i, vec_q[i], run_ok);
        if (!run_ok) begin
          timed_out = 1'b1;
          break;
        end
      end
    end
    $display("%0d tests: %0d passed, %0d failed, %0d check errors",
             vec_q.size(), pass_cnt, fail_cnt, err_cnt);
    if (!timed_out && err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
rtl/md_op_pkg.sv
rtl/md_arith_pkg.sv
rtl/md_mult_fast.sv
rtl/md_div_long.sv
rtl/md_unit.sv
bench/md_clk_gen.sv
bench/md_unit_properties.sv
bench/md_unit_tb.sv

/* Makefile */
# Verilator flow for the RV32M multiply/divide unit
#   make        build if needed and run
#   make run    same
#   make clean  remove build output and log

SIM  := obj_dir/Vmd_unit_tb
SRCS := $(shell grep -v '^+' all.f) rtl/md_params.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
	  -f all.f --top-module md_unit_tb

# the log decides, the simulator status is not trusted alone
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
	  echo "simulation failed, see sim.log"; \
	  exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" sim.log; then \
	  echo "simulation ended without a result line, see sim.log"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
